// File: Makefile
# Verilator build and run of the switch fabric testbench

VERILATOR ?= verilator
TOP       ?= tb_switch_fabric
FILELIST  ?= switch_fabric.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= STATUS: FAIL
PASS_MSG  ?= STATUS: PASS

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/fabric_assert.sv
`timescale 1ns/1ps
`default_nettype none

module fabric_assert #(
	parameter int NUM_PORTS			= 15,
	parameter int MAX_FRAME_WORDS	= 96
) (
	input logic								clk_ram_ctl,
	input logic								rst,
	input fabric_pkg::frame_beat_t			out_beat,
	input logic [NUM_PORTS-1:0]				out_port_wr,
	input logic [NUM_PORTS-1:0]				frame_port_wr,
	input logic [fabric_pkg::LEN_W-1:0]		frame_len,
	input logic [NUM_PORTS-1:0]				port_space_avail
);

	import fabric_pkg::*;

	// Write mask only rides on a valid output word
	assert property (@(posedge clk_ram_ctl) disable iff (rst)
		(out_port_wr != '0) |-> out_beat.valid)
		else $error("Output write mask set without a valid output word");

	// Reserved length stays within the legal frame range
	assert property (@(posedge clk_ram_ctl) disable iff (rst)
		(frame_port_wr != '0) |-> ((frame_len >= LEN_W'(1))
			&& (frame_len <= LEN_W'(MAX_FRAME_WORDS))))
		else $error("Reservation with an illegal frame length");

	// Pulse comes from the flags seen one cycle earlier
	assert property (@(posedge clk_ram_ctl) disable iff (rst)
		(frame_port_wr != '0) |-> ((frame_port_wr & ~$past(port_space_avail)) == '0))
		else $error("Reservation on a port without space");

endmodule

// Checker rides inside every forwarding engine
bind forward_decision fabric_assert #(
	.NUM_PORTS(NUM_PORTS),
	.MAX_FRAME_WORDS(MAX_FRAME_WORDS)
) fwd_checks (
	.clk_ram_ctl(clk_ram_ctl),
	.rst(rst),
	.out_beat(out_beat),
	.out_port_wr(out_port_wr),
	.frame_port_wr(frame_port_wr),
	.frame_len(frame_len),
	.port_space_avail(port_space_avail)
);

`default_nettype wire

// File: sim/tb_switch_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module tb_switch_fabric;

	import fabric_pkg::*;

	localparam int NUM_PORTS		= 15;
	localparam int MAX_FRAME_WORDS	= 96;
	localparam int QUEUE_DEPTH		= 512;
	localparam int WAIT_LIMIT		= 200;
	localparam int IDLE_GAP			= 4;

	logic					clk_ram_ctl;
	logic					rst;
	cfg_write_t				cfg;
	frame_beat_t			in_beat;
	logic [NUM_PORTS-1:0]	port_credit_return;
	frame_beat_t			out_beat;
	logic [NUM_PORTS-1:0]	out_port_wr;
	logic [15:0]			frames_dropped;

	// Words left in each egress queue, kept from the credit rule
	int credit_model [NUM_PORTS];

	// Frames with an empty destination set since reset
	int drops_expected;

	int error_count;
	int tests_run;
	int tests_failed;

	switch_fabric_top #(
		.NUM_PORTS(NUM_PORTS),
		.MAX_FRAME_WORDS(MAX_FRAME_WORDS),
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) DUT (
		.clk_ram_ctl(clk_ram_ctl),
		.rst(rst),
		.cfg(cfg),
		.in_beat(in_beat),
		.port_credit_return(port_credit_return),
		.out_beat(out_beat),
		.out_port_wr(out_port_wr),
		.frames_dropped(frames_dropped)
	);

	initial clk_ram_ctl = 1'b0;
	always #50 clk_ram_ctl = ~clk_ram_ctl;

	//////////////////////////////////////////////////
	// Output capture on the falling edge

	logic [DATA_W-1:0]		got_data [$];
	logic					got_last [$];
	logic [NUM_PORTS-1:0]	got_mask [$];
	logic [15:0]			drops_seen;

	always @(negedge clk_ram_ctl) begin
		drops_seen <= frames_dropped;
		if (out_beat.valid) begin
			got_data.push_back(out_beat.word.raw);
			got_last.push_back(out_beat.last);
			got_mask.push_back(out_port_wr);
		end
	end

	//////////////////////////////////////////////////
	// Helpers

	function automatic logic [NUM_PORTS-1:0] port_bit(input int p);
		logic [NUM_PORTS-1:0] m;
		m = '0;
		m[p] = 1'b1;
		return m;
	endfunction

	task automatic check_value(input string test, input string what,
			input logic [DATA_W-1:0] expected, input logic [DATA_W-1:0] actual);
		if (expected !== actual) begin
			$display("Mismatch in %s, %s: expected %0h, actual %0h", test, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic report_failure(input string test, input string msg);
		$display("Failure in %s: %s", test, msg);
		error_count++;
	endtask

	task automatic finish_test(input string test, input int errors_before);
		tests_run++;
		if (error_count == errors_before) begin
			$display("%s: ok", test);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", test, error_count - errors_before);
		end
	endtask

	task automatic write_cfg(input int port, input int vlan, input logic trunk);
		cfg_write_t c;
		c.en = 1'b1;
		c.port = PORT_ID_W'(port);
		c.vlan = VLAN_W'(vlan);
		c.trunk = trunk;
		@(posedge clk_ram_ctl);
		cfg <= c;
		@(posedge clk_ram_ctl);
		cfg <= '0;
	endtask

	// One pulse per cycle on a single port
	task automatic return_credits(input int port, input int count);
		for (int i = 0; i < count; i++) begin
			@(posedge clk_ram_ctl);
			port_credit_return <= port_bit(port);
		end
		@(posedge clk_ram_ctl);
		port_credit_return <= '0;
		credit_model[port] += count;
	endtask

	// Sends header plus payload, then checks words, mask and drop count
	task automatic run_frame(input string test, input int src, input int vlan,
			input int hdr_len, input int n_words, input logic [NUM_PORTS-1:0] exp_mask);
		frame_beat_t		b;
		logic [DATA_W-1:0]	sent [$];
		int					t;
		if (exp_mask == '0)
			drops_expected++;
		got_data.delete();
		got_last.delete();
		got_mask.delete();
		b = '0;
		b.valid = 1'b1;
		b.word.hdr.src_port = PORT_ID_W'(src);
		b.word.hdr.vlan = VLAN_W'(vlan);
		b.word.hdr.len = LEN_W'(hdr_len);
		@(posedge clk_ram_ctl);
		in_beat <= b;
		for (int i = 0; i < n_words; i++) begin
			b.word.raw = {$urandom, $urandom, $urandom, $urandom};
			b.last = (i == n_words - 1);
			sent.push_back(b.word.raw);
			@(posedge clk_ram_ctl);
			in_beat <= b;
		end
		@(posedge clk_ram_ctl);
		in_beat <= '0;
		t = 0;
		if (exp_mask != '0) begin
			while (got_data.size() < n_words && t < WAIT_LIMIT) begin
				@(posedge clk_ram_ctl);
				t++;
			end
		end else begin
			while (drops_seen !== 16'(drops_expected) && t < WAIT_LIMIT) begin
				@(posedge clk_ram_ctl);
				t++;
			end
		end
		if (t >= WAIT_LIMIT)
			report_failure(test, "frame neither came out nor was counted as dropped in time");
		// Flags need a few quiet cycles before the next header
		repeat (IDLE_GAP) @(posedge clk_ram_ctl);
		check_value(test, "word count", DATA_W'((exp_mask != '0) ? n_words : 0),
			DATA_W'(got_data.size()));
		for (int i = 0; i < got_data.size() && i < sent.size(); i++) begin
			check_value(test, "payload", sent[i], got_data[i]);
			check_value(test, "last flag", DATA_W'(i == n_words - 1), DATA_W'(got_last[i]));
			check_value(test, "port mask", DATA_W'(exp_mask), DATA_W'(got_mask[i]));
		end
		check_value(test, "drop count", DATA_W'(drops_expected), DATA_W'(drops_seen));
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (exp_mask[p])
				credit_model[p] -= hdr_len;
		end
	endtask

	//////////////////////////////////////////////////
	// Directed tests

	task automatic access_forwarding();
		int start;
		start = error_count;
		write_cfg(0, 5, 1'b0);
		write_cfg(3, 5, 1'b0);
		write_cfg(7, 5, 1'b0);
		write_cfg(9, 1, 1'b1);
		run_frame("access_forwarding", 0, 5, 4, 4, port_bit(3) | port_bit(7) | port_bit(9));
		finish_test("access_forwarding", start);
	endtask

	task automatic ingress_filtering();
		int start;
		start = error_count;
		run_frame("ingress_filtering", 0, 8, 3, 3, '0);
		finish_test("ingress_filtering", start);
	endtask

	task automatic trunk_source();
		int start;
		start = error_count;
		run_frame("trunk_source", 9, 5, 3, 3, port_bit(0) | port_bit(3) | port_bit(7));
		// No port lives on VLAN 77
		run_frame("trunk_source", 9, 77, 2, 2, '0);
		finish_test("trunk_source", start);
	endtask

	task automatic length_check();
		int start;
		start = error_count;
		run_frame("length_check", 0, 5, 0, 1, '0);
		run_frame("length_check", 0, 5, MAX_FRAME_WORDS + 1, MAX_FRAME_WORDS + 1, '0);
		run_frame("length_check", 0, 5, MAX_FRAME_WORDS, MAX_FRAME_WORDS,
			port_bit(3) | port_bit(7) | port_bit(9));
		finish_test("length_check", start);
	endtask

	task automatic egress_credits();
		int start;
		int c;
		int n_fwd;
		start = error_count;
		// Ports 0 and 3 alone on VLAN 20, port 9 back to access
		write_cfg(0, 20, 1'b0);
		write_cfg(3, 20, 1'b0);
		write_cfg(9, 1, 1'b0);
		c = credit_model[3];
		n_fwd = 0;
		while (c >= 2 * MAX_FRAME_WORDS) begin
			c -= MAX_FRAME_WORDS;
			n_fwd++;
		end
		for (int i = 0; i < n_fwd; i++)
			run_frame("egress_credits", 0, 20, MAX_FRAME_WORDS, MAX_FRAME_WORDS, port_bit(3));
		run_frame("egress_credits", 0, 20, MAX_FRAME_WORDS, MAX_FRAME_WORDS, '0);
		// Back up to the threshold exactly
		return_credits(3, 2 * MAX_FRAME_WORDS - credit_model[3]);
		repeat (4) @(posedge clk_ram_ctl);
		run_frame("egress_credits", 0, 20, MAX_FRAME_WORDS, MAX_FRAME_WORDS, port_bit(3));
		finish_test("egress_credits", start);
	endtask

	//////////////////////////////////////////////////
	// Main sequence

	initial begin
		void'($urandom(32'h3b99));
		cfg = '0;
		in_beat = '0;
		port_credit_return = '0;
		rst = 1'b1;
		error_count = 0;
		tests_run = 0;
		tests_failed = 0;
		drops_expected = 0;
		for (int p = 0; p < NUM_PORTS; p++)
			credit_model[p] = QUEUE_DEPTH;
		repeat (5) @(posedge clk_ram_ctl);
		rst <= 1'b0;
		repeat (IDLE_GAP) @(posedge clk_ram_ctl);
		access_forwarding();
		ingress_filtering();
		trunk_source();
		length_check();
		egress_credits();
		$display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	// Hard stop well past the expected run length
	initial begin
		#2000000;
		$display("Simulation ran past its time limit");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/egress_credit_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module egress_credit_tracker #(
	parameter int NUM_PORTS			= 15,
	parameter int MAX_FRAME_WORDS	= 96,
	parameter int QUEUE_DEPTH		= 512
) (
	input logic								clk_ram_ctl,
	input logic								rst,

	// Reservations from the forwarding engine
	input logic [NUM_PORTS-1:0]				frame_port_wr,
	input logic [fabric_pkg::LEN_W-1:0]		frame_len,

	// One word freed per pulse
	input logic [NUM_PORTS-1:0]				port_credit_return,

	// Registered space flags
	output logic [NUM_PORTS-1:0]			port_space_avail
);

	//////////////////////////////////////////////////
	// Counter sizing

	// Wide enough to hold a full queue
	localparam int CREDIT_W = $clog2(QUEUE_DEPTH + 1);

	localparam logic [CREDIT_W-1:0] CREDIT_FULL = CREDIT_W'(QUEUE_DEPTH);

	// Room for one frame plus one still in flight
	localparam logic [CREDIT_W-1:0] SPACE_MIN = CREDIT_W'(2 * MAX_FRAME_WORDS);

	//////////////////////////////////////////////////
	// Per-port credit counters

	logic [CREDIT_W-1:0] credit [NUM_PORTS];

	// Reservation size seen by every port
	logic [CREDIT_W-1:0] len_credits;

	assign len_credits = CREDIT_W'(frame_len);

	// Take and give back can land in the same cycle
	always_ff @(posedge clk_ram_ctl) begin
		if (rst) begin
			for (int p = 0; p < NUM_PORTS; p++)
				credit[p] <= CREDIT_FULL;
		end else begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				credit[p] <= credit[p]
					- (frame_port_wr[p] ? len_credits : '0)
					+ CREDIT_W'(port_credit_return[p]);
			end
		end
	end

	//////////////////////////////////////////////////
	// Space flags

	// Compare stage
	logic [NUM_PORTS-1:0] space_raw;

	always_comb begin
		for (int p = 0; p < NUM_PORTS; p++)
			space_raw[p] = (credit[p] >= SPACE_MIN);
	end

	// Extra flop for timing, flags low for the first cycle
	always_ff @(posedge clk_ram_ctl) begin
		if (rst)
			port_space_avail <= '0;
		else
			port_space_avail <= space_raw;
	end

endmodule

`default_nettype wire

// File: source/fabric_pkg.sv
`default_nettype none

package fabric_pkg;

	//////////////////////////////////////////////////
	// Widths

	// One frame word on the internal bus
	localparam int DATA_W = 128;

	// 802.1Q VLAN ID
	localparam int VLAN_W = 12;

	// Payload length, counted in words
	localparam int LEN_W = 11;

	// Port number, room for up to 16 ports
	localparam int PORT_ID_W = 4;

	// Header bits left over after the used fields
	localparam int HDR_PAD_W = DATA_W - PORT_ID_W - VLAN_W - LEN_W;

	//////////////////////////////////////////////////
	// Frame stream types

	typedef logic [VLAN_W-1:0] vlan_t;

	// First word of every frame, MSB first
	typedef struct packed {
		logic [PORT_ID_W-1:0]	src_port;
		vlan_t					vlan;
		logic [LEN_W-1:0]		len;
		logic [HDR_PAD_W-1:0]	rsvd;
	} frame_header_t;

	// Header on the first word, raw payload on the rest
	typedef union packed {
		frame_header_t			hdr;
		logic [DATA_W-1:0]		raw;
	} frame_word_u;

	typedef struct packed {
		logic					valid;
		logic					last;
		frame_word_u			word;
	} frame_beat_t;

	//////////////////////////////////////////////////
	// Configuration

	// Single VLAN table entry write
	typedef struct packed {
		logic					en;
		logic [PORT_ID_W-1:0]	port;
		vlan_t					vlan;
		logic					trunk;
	} cfg_write_t;

endpackage

`default_nettype wire

// File: source/forward_decision.sv
`timescale 1ns/1ps
`default_nettype none

module forward_decision #(
	parameter int NUM_PORTS			= 15,
	parameter int MAX_FRAME_WORDS	= 96
) (
	input logic									clk_ram_ctl,
	input logic									rst,

	// Incoming frame words, one per cycle, never stalled
	input fabric_pkg::frame_beat_t				in_beat,

	// Port configuration
	input fabric_pkg::vlan_t [NUM_PORTS-1:0]	port_vlan,
	input logic [NUM_PORTS-1:0]					port_trunk,

	// Egress space flags, already two cycles old
	input logic [NUM_PORTS-1:0]					port_space_avail,

	// Queue reservation, one-cycle pulse per frame
	output logic [NUM_PORTS-1:0]				frame_port_wr,
	output logic [fabric_pkg::LEN_W-1:0]		frame_len,

	// Forwarded payload
	output fabric_pkg::frame_beat_t				out_beat,
	output logic [NUM_PORTS-1:0]				out_port_wr,

	// Frames with no destination
	output logic [15:0]							frames_dropped
);

	import fabric_pkg::*;

	//////////////////////////////////////////////////
	// Frame framing

	// High when the next valid word is a header
	logic expect_hdr;

	logic hdr_fire;
	logic payload_fire;

	assign hdr_fire		= in_beat.valid && expect_hdr;
	assign payload_fire	= in_beat.valid && !expect_hdr;

	// Any word with last closes the frame, header included
	always_ff @(posedge clk_ram_ctl) begin
		if (rst)
			expect_hdr <= 1'b1;
		else if (in_beat.valid)
			expect_hdr <= in_beat.last;
	end

	//////////////////////////////////////////////////
	// Destination choice

	frame_header_t hdr;

	// Ports that carry the header VLAN
	logic [NUM_PORTS-1:0] member;

	// One-hot source port, zero if out of range
	logic [NUM_PORTS-1:0] src_mask;

	logic len_ok;
	logic ingress_ok;
	logic [NUM_PORTS-1:0] dest;

	assign hdr = in_beat.word.hdr;

	always_comb begin
		for (int p = 0; p < NUM_PORTS; p++) begin
			member[p]	= port_trunk[p] || (port_vlan[p] == hdr.vlan);
			src_mask[p]	= (int'(hdr.src_port) == p);
		end
	end

	// Zero words or oversize frames go nowhere
	assign len_ok = (hdr.len != '0) && (hdr.len <= LEN_W'(MAX_FRAME_WORDS));

	// Source must exist and be a trunk or sit on the header VLAN
	assign ingress_ok = |(src_mask & member);

	// No hairpin back to the source, full queues left out
	assign dest = (len_ok && ingress_ok) ? (member & ~src_mask & port_space_avail) : '0;

	//////////////////////////////////////////////////
	// Reservation and drop count

	// Mask held for the rest of the frame
	logic [NUM_PORTS-1:0] fwd_mask;

	always_ff @(posedge clk_ram_ctl) begin
		if (rst) begin
			frame_port_wr	<= '0;
			fwd_mask		<= '0;
			frames_dropped	<= '0;
		end else begin
			frame_port_wr <= hdr_fire ? dest : '0;
			if (hdr_fire)
				fwd_mask <= dest;

			// Saturate rather than wrap
			if (hdr_fire && (dest == '0) && (frames_dropped != '1))
				frames_dropped <= frames_dropped + 16'd1;
		end
	end

	// Length only matters alongside a nonzero pulse
	always_ff @(posedge clk_ram_ctl) begin
		if (hdr_fire)
			frame_len <= hdr.len;
	end

	//////////////////////////////////////////////////
	// Payload path, one cycle of latency

	logic			out_valid_q;
	logic			out_last_q;
	frame_word_u	out_word_q;

	always_ff @(posedge clk_ram_ctl) begin
		if (rst) begin
			out_valid_q	<= 1'b0;
			out_port_wr	<= '0;
		end else begin
			// Words of dropped frames are swallowed here
			out_valid_q	<= payload_fire && (fwd_mask != '0);
			out_port_wr	<= payload_fire ? fwd_mask : '0;
		end
	end

	always_ff @(posedge clk_ram_ctl) begin
		out_last_q	<= in_beat.last;
		out_word_q	<= in_beat.word;
	end

	assign out_beat = '{valid: out_valid_q, last: out_last_q, word: out_word_q};

endmodule

`default_nettype wire

// File: source/switch_fabric_top.sv
`timescale 1ns/1ps
`default_nettype none

module switch_fabric_top #(
	parameter int NUM_PORTS			= 15,
	parameter int MAX_FRAME_WORDS	= 96,
	parameter int QUEUE_DEPTH		= 512
) (
	input logic							clk_ram_ctl,
	input logic							rst,

	// Table writes
	input fabric_pkg::cfg_write_t		cfg,

	// Frame stream in
	input fabric_pkg::frame_beat_t		in_beat,

	// Egress queue credit returns
	input logic [NUM_PORTS-1:0]			port_credit_return,

	// Frame stream out with per-port write mask
	output fabric_pkg::frame_beat_t		out_beat,
	output logic [NUM_PORTS-1:0]		out_port_wr,

	output logic [15:0]					frames_dropped
);

	import fabric_pkg::*;

	//////////////////////////////////////////////////
	// Port configuration

	vlan_t [NUM_PORTS-1:0]	port_vlan;
	logic [NUM_PORTS-1:0]	port_trunk;

	vlan_port_table #(
		.NUM_PORTS(NUM_PORTS)
	) vlan_table (
		.clk_ram_ctl(clk_ram_ctl),
		.rst(rst),
		.cfg(cfg),
		.port_vlan(port_vlan),
		.port_trunk(port_trunk)
	);

	//////////////////////////////////////////////////
	// Forwarding engine

	logic [NUM_PORTS-1:0]	port_space_avail;
	logic [NUM_PORTS-1:0]	frame_port_wr;
	logic [LEN_W-1:0]		frame_len;

	forward_decision #(
		.NUM_PORTS(NUM_PORTS),
		.MAX_FRAME_WORDS(MAX_FRAME_WORDS)
	) fwd (
		.clk_ram_ctl(clk_ram_ctl),
		.rst(rst),
		.in_beat(in_beat),
		.port_vlan(port_vlan),
		.port_trunk(port_trunk),
		.port_space_avail(port_space_avail),
		.frame_port_wr(frame_port_wr),
		.frame_len(frame_len),
		.out_beat(out_beat),
		.out_port_wr(out_port_wr),
		.frames_dropped(frames_dropped)
	);

	//////////////////////////////////////////////////
	// Egress queue accounting

	// Flags come back registered, loop latency of two
	egress_credit_tracker #(
		.NUM_PORTS(NUM_PORTS),
		.MAX_FRAME_WORDS(MAX_FRAME_WORDS),
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) credits (
		.clk_ram_ctl(clk_ram_ctl),
		.rst(rst),
		.frame_port_wr(frame_port_wr),
		.frame_len(frame_len),
		.port_credit_return(port_credit_return),
		.port_space_avail(port_space_avail)
	);

endmodule

`default_nettype wire

// File: source/vlan_port_table.sv
`timescale 1ns/1ps
`default_nettype none

module vlan_port_table #(
	parameter int NUM_PORTS = 15
) (
	input logic								clk_ram_ctl,
	input logic								rst,

	// Entry writes
	input fabric_pkg::cfg_write_t			cfg,

	// Current table contents
	output fabric_pkg::vlan_t [NUM_PORTS-1:0]	port_vlan,
	output logic [NUM_PORTS-1:0]				port_trunk
);

	import fabric_pkg::*;

	// Default VLAN out of reset, all ports in access mode
	localparam vlan_t VLAN_DEFAULT = VLAN_W'(1);

	//////////////////////////////////////////////////
	// Write decode

	// Write targets an existing port
	logic cfg_hit;

	// One-hot select of the entry being written
	logic [NUM_PORTS-1:0] entry_sel;

	assign cfg_hit = cfg.en && (int'(cfg.port) < NUM_PORTS);

	always_comb begin
		for (int p = 0; p < NUM_PORTS; p++) begin
			entry_sel[p] = cfg_hit && (int'(cfg.port) == p);
		end
	end

	//////////////////////////////////////////////////
	// Table registers

	// New value visible right after the write edge
	always_ff @(posedge clk_ram_ctl) begin
		if (rst) begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				port_vlan[p]	<= VLAN_DEFAULT;
				port_trunk[p]	<= 1'b0;
			end
		end else begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				if (entry_sel[p]) begin
					port_vlan[p]	<= cfg.vlan;
					port_trunk[p]	<= cfg.trunk;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: switch_fabric.f
source/fabric_pkg.sv
source/vlan_port_table.sv
source/forward_decision.sv
source/egress_credit_tracker.sv
source/switch_fabric_top.sv
sim/fabric_assert.sv
sim/tb_switch_fabric.sv
